//--- logic/hockey_pkg.sv
package hockey_pkg;

    typedef logic [2:0] coord_t;   // row or column on the 5x5 grid
    typedef logic [1:0] score_t;

    localparam coord_t GRID_MAX = 3'd4;
    localparam coord_t COL_A    = 3'd0;   // goal line of player A
    localparam coord_t COL_B    = 3'd4;   // goal line of player B

    typedef enum logic [1:0] {
        AIM_STRAIGHT = 2'b00,
        AIM_UP       = 2'b01,   // row rises
        AIM_DOWN     = 2'b10    // row falls, 2'b11 acts as straight
    } aim_t;

    typedef enum logic {
        PLAYER_A = 1'b0,
        PLAYER_B = 1'b1
    } player_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_FACEOFF,
        PH_SERVE,
        PH_TRAVEL,
        PH_RESPOND,
        PH_GOAL,
        PH_OVER
    } phase_t;

    localparam logic KIND_SERVE  = 1'b0;
    localparam logic KIND_RETURN = 1'b1;

    typedef struct packed {
        logic   press;
        aim_t   aim;
        coord_t row;
    } paddle_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } puck_pos_t;

    typedef struct packed {
        logic    kind;   // serve or return
        player_t side;   // who strikes
        aim_t    aim;
        coord_t  row;
    } strike_t;

endpackage

//--- logic/pace_timer.sv
`timescale 1ns/1ps

module pace_timer #(
    parameter int TICKS = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic tick
);

    localparam int CW = (TICKS > 1) ? $clog2(TICKS) : 1;
    localparam logic [CW-1:0] LAST = CW'(TICKS - 1);

    logic [CW-1:0] count;

    // wrap cycle of the period
    assign tick = (count == LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;   // phase entry starts a fresh period
        end else if (tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- logic/puck_mover.sv
`timescale 1ns/1ps

module puck_mover import hockey_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      strike_valid,
    input  strike_t   strike,
    input  logic      step,
    output puck_pos_t puck,
    output logic      arrived
);

    puck_pos_t pos_q;
    aim_t      aim_q;
    coord_t    goal_q;      // goal column the puck is heading to

    logic      is_return;
    aim_t      src_aim;
    coord_t    src_goal;
    puck_pos_t moved;
    aim_t      moved_aim;

    function automatic coord_t home_col(player_t p);
        return (p == PLAYER_A) ? COL_A : COL_B;
    endfunction

    function automatic coord_t far_col(player_t p);
        return (p == PLAYER_A) ? COL_B : COL_A;
    endfunction

    // a return steps at once with the new aim and heading
    assign is_return = strike_valid && (strike.kind == KIND_RETURN);
    assign src_aim   = is_return ? strike.aim : aim_q;
    assign src_goal  = is_return ? far_col(strike.side) : goal_q;

    always_comb begin
        moved.x   = (src_goal > pos_q.x) ? pos_q.x + 3'd1 : pos_q.x - 3'd1;
        moved.y   = pos_q.y;
        moved_aim = src_aim;
        case (src_aim)
            AIM_UP: begin
                if (pos_q.y >= GRID_MAX) begin
                    moved_aim = AIM_DOWN;       // top wall
                    moved.y   = pos_q.y - 3'd1;
                end else begin
                    moved.y = pos_q.y + 3'd1;
                end
            end
            AIM_DOWN: begin
                if (pos_q.y == '0) begin
                    moved_aim = AIM_UP;         // bottom wall
                    moved.y   = pos_q.y + 3'd1;
                end else begin
                    moved.y = pos_q.y - 3'd1;
                end
            end
            default: begin
                moved.y = pos_q.y;              // straight
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_q  <= '0;
            aim_q  <= AIM_STRAIGHT;
            goal_q <= COL_B;
        end else if (strike_valid) begin
            goal_q <= far_col(strike.side);
            if (strike.kind == KIND_SERVE) begin
                pos_q.x <= home_col(strike.side);
                pos_q.y <= strike.row;
                aim_q   <= strike.aim;
            end else begin
                pos_q <= moved;
                aim_q <= moved_aim;
            end
        end else if (step) begin
            pos_q <= moved;
            aim_q <= moved_aim;
        end
    end

    assign puck = pos_q;

    // step that lands on the far goal line
    assign arrived = step && !strike_valid && (moved.x == goal_q);

endmodule

//--- logic/rink_ctrl.sv
`timescale 1ns/1ps

module rink_ctrl import hockey_pkg::*; #(
    parameter int TICKS     = 100,
    parameter int WIN_SCORE = 3
) (
    input  logic      clk,
    input  logic      rst,
    input  paddle_t   paddle_a,
    input  paddle_t   paddle_b,
    input  logic      tick,
    input  puck_pos_t puck,
    input  logic      arrived,
    output logic      restart,
    output logic      step,
    output logic      strike_valid,
    output strike_t   strike,
    output score_t    score_a,
    output score_t    score_b,
    output logic      game_over,
    output player_t   winner
);

    if (TICKS < 1 || WIN_SCORE < 1 || WIN_SCORE > 3) begin : g_param_check
        $error("rink_ctrl: TICKS must be >= 1 and WIN_SCORE within 1..3");
    end

    phase_t  phase;
    phase_t  phase_nxt;
    player_t side;          // server until the serve, attacker after it
    player_t other;
    paddle_t own_pad;
    paddle_t opp_pad;
    logic    in_respond;
    logic    start_ok;
    logic    serve_ok;
    logic    return_ok;
    logic    win_reached;

    assign other   = (side == PLAYER_A) ? PLAYER_B : PLAYER_A;
    assign own_pad = (side == PLAYER_A) ? paddle_a : paddle_b;
    assign opp_pad = (side == PLAYER_A) ? paddle_b : paddle_a;

    assign in_respond  = (phase == PH_RESPOND);
    assign start_ok    = paddle_a.press ^ paddle_b.press;   // exactly one player
    assign serve_ok    = own_pad.press && (own_pad.row <= GRID_MAX);
    assign return_ok   = opp_pad.press && (opp_pad.row == puck.y);
    assign win_reached = (score_a == score_t'(WIN_SCORE)) ||
                         (score_b == score_t'(WIN_SCORE));

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: begin
                if (start_ok) begin
                    phase_nxt = PH_FACEOFF;
                end
            end
            PH_FACEOFF: begin
                if (tick) begin
                    phase_nxt = PH_SERVE;
                end
            end
            PH_SERVE: begin
                if (serve_ok) begin
                    phase_nxt = PH_TRAVEL;
                end
            end
            PH_TRAVEL: begin
                if (arrived) begin
                    phase_nxt = PH_RESPOND;
                end
            end
            PH_RESPOND: begin
                if (return_ok) begin
                    phase_nxt = PH_TRAVEL;
                end else if (tick) begin
                    phase_nxt = PH_GOAL;    // window closed
                end
            end
            PH_GOAL: begin
                if (tick) begin
                    phase_nxt = win_reached ? PH_OVER : PH_SERVE;
                end
            end
            default: begin
                phase_nxt = PH_OVER;        // end state holds
            end
        endcase
    end

    // restart on every phase entry so each phase gets a full period
    assign restart      = (phase_nxt != phase);
    assign step         = (phase == PH_TRAVEL) && tick;
    assign strike_valid = ((phase == PH_SERVE) && serve_ok) || (in_respond && return_ok);

    always_comb begin
        strike.kind = in_respond ? KIND_RETURN : KIND_SERVE;
        strike.side = in_respond ? other : side;
        strike.aim  = in_respond ? opp_pad.aim : own_pad.aim;
        strike.row  = in_respond ? opp_pad.row : own_pad.row;
    end

    assign game_over = (phase == PH_OVER);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= PH_IDLE;
            side    <= PLAYER_A;
            score_a <= '0;
            score_b <= '0;
            winner  <= PLAYER_A;
        end else begin
            phase <= phase_nxt;
            case (phase)
                PH_IDLE: begin
                    if (start_ok) begin
                        side <= paddle_a.press ? PLAYER_A : PLAYER_B;
                    end
                end
                PH_RESPOND: begin
                    if (return_ok) begin
                        side <= other;              // defender now attacks
                    end else if (tick) begin
                        if (side == PLAYER_A) begin
                            score_a <= score_a + 2'd1;
                        end else begin
                            score_b <= score_b + 2'd1;
                        end
                        side <= other;              // scored upon serves next
                    end
                end
                PH_GOAL: begin
                    if (tick && win_reached) begin
                        winner <= other;            // side already flipped
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- logic/hockey_top.sv
`timescale 1ns/1ps

module hockey_top import hockey_pkg::*; #(
    parameter int TICKS     = 100,
    parameter int WIN_SCORE = 3
) (
    input  logic      clk,
    input  logic      rst,
    input  paddle_t   paddle_a,
    input  paddle_t   paddle_b,
    output puck_pos_t puck,
    output score_t    score_a,
    output score_t    score_b,
    output logic      game_over,
    output player_t   winner
);

    logic    tick;
    logic    restart;
    logic    step;
    logic    strike_valid;
    logic    arrived;
    strike_t strike;

    rink_ctrl #(
        .TICKS     (TICKS),
        .WIN_SCORE (WIN_SCORE)
    ) i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .paddle_a     (paddle_a),
        .paddle_b     (paddle_b),
        .tick         (tick),
        .puck         (puck),
        .arrived      (arrived),
        .restart      (restart),
        .step         (step),
        .strike_valid (strike_valid),
        .strike       (strike),
        .score_a      (score_a),
        .score_b      (score_b),
        .game_over    (game_over),
        .winner       (winner)
    );

    pace_timer #(
        .TICKS (TICKS)
    ) i_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .tick    (tick)
    );

    puck_mover i_puck (
        .clk          (clk),
        .rst          (rst),
        .strike_valid (strike_valid),
        .strike       (strike),
        .step         (step),
        .puck         (puck),
        .arrived      (arrived)
    );

endmodule

//--- test/hockey_sva.sv
`timescale 1ns/1ps

module hockey_sva import hockey_pkg::*; #(
    parameter int WIN_SCORE = 3
) (
    input logic      clk,
    input logic      rst,
    input puck_pos_t puck,
    input score_t    score_a,
    input score_t    score_b,
    input logic      game_over
);

    a_grid: assert property (@(posedge clk) disable iff (rst)
        (puck.x <= GRID_MAX) && (puck.y <= GRID_MAX))
        else $error("puck left the grid");

    // winning score is the ceiling
    a_score_a: assert property (@(posedge clk) disable iff (rst)
        (score_a == score_t'(WIN_SCORE)) |=> (score_a == score_t'(WIN_SCORE)))
        else $error("score a counted past the winning score");

    a_score_b: assert property (@(posedge clk) disable iff (rst)
        (score_b == score_t'(WIN_SCORE)) |=> (score_b == score_t'(WIN_SCORE)))
        else $error("score b counted past the winning score");

    // end state is final
    a_over_sticky: assert property (@(posedge clk) disable iff (rst)
        game_over |=> game_over)
        else $error("game_over fell after the end of the game");

endmodule

bind hockey_top hockey_sva #(
    .WIN_SCORE (WIN_SCORE)
) i_sva (
    .clk       (clk),
    .rst       (rst),
    .puck      (puck),
    .score_a   (score_a),
    .score_b   (score_b),
    .game_over (game_over)
);

//--- test/hockey_tb.sv
`timescale 1ns/1ps

module hockey_tb import hockey_pkg::*; ();

    localparam int TICKS           = 4;
    localparam int WIN_SCORE       = 3;
    localparam int RALLIES         = 4;
    localparam int WATCHDOG_CYCLES = RALLIES * 12 * TICKS + 200;

    localparam logic [1:0] PEND_NONE   = 2'd0;
    localparam logic [1:0] PEND_SERVE  = 2'd1;
    localparam logic [1:0] PEND_RETURN = 2'd2;

    typedef struct packed {
        puck_pos_t pos;
        aim_t      aim;
        coord_t    goal;
    } puck_state_t;

    logic        clk;
    logic        rst;
    paddle_t     paddle_a;
    paddle_t     paddle_b;
    puck_pos_t   puck;
    score_t      score_a;
    score_t      score_b;
    logic        game_over;
    player_t     winner;

    puck_state_t model;         // puck as the rules predict it
    logic [1:0]  pend_kind;     // strike on its way into the DUT
    player_t     pend_side;
    aim_t        pend_aim;
    coord_t      pend_row;
    score_t      exp_score_a;
    score_t      exp_score_b;
    puck_pos_t   held_puck;
    int          seed;

    hockey_top #(.TICKS(TICKS), .WIN_SCORE(WIN_SCORE)) i_dut (
        .clk(clk), .rst(rst), .paddle_a(paddle_a), .paddle_b(paddle_b), .puck(puck),
        .score_a(score_a), .score_b(score_b), .game_over(game_over), .winner(winner)
    );

    function automatic coord_t home_of(player_t p);
        return (p == PLAYER_A) ? COL_A : COL_B;
    endfunction

    function automatic coord_t goal_of(player_t p);
        return (p == PLAYER_A) ? COL_B : COL_A;
    endfunction

    // one travel step: column toward goal, row by aim, flip at the walls
    function automatic puck_state_t ref_step(puck_state_t s);
        puck_state_t n;
        n = s;
        n.pos.x = (s.goal > s.pos.x) ? s.pos.x + 3'd1 : s.pos.x - 3'd1;
        if (s.aim == AIM_UP) begin
            n.aim   = (s.pos.y == GRID_MAX) ? AIM_DOWN : AIM_UP;
            n.pos.y = (s.pos.y == GRID_MAX) ? s.pos.y - 3'd1 : s.pos.y + 3'd1;
        end else if (s.aim == AIM_DOWN) begin
            n.aim   = (s.pos.y == 3'd0) ? AIM_UP : AIM_DOWN;
            n.pos.y = (s.pos.y == 3'd0) ? s.pos.y + 3'd1 : s.pos.y - 3'd1;
        end
        return n;
    endfunction

    function automatic paddle_t make_pad(logic press, aim_t aim, coord_t row);
        paddle_t p;
        p.press = press;
        p.aim   = aim;
        p.row   = row;
        return p;
    endfunction

    function automatic paddle_t random_pad();
        logic [31:0] r;
        r = $random(seed);
        return make_pad(r[0], aim_t'(r[2:1]), r[5:3]);
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic drive_pad(player_t p, paddle_t v);
        if (p == PLAYER_A) paddle_a = v;
        else paddle_b = v;
    endtask

    task automatic check_puck(coord_t x, coord_t y);
        check_value("puck x", 32'(puck.x), 32'(x));
        check_value("puck y", 32'(puck.y), 32'(y));
    endtask

    // hold the press until the load edge, which the phase timing fixes
    task automatic serve_puck(player_t p, coord_t row, aim_t aim, int edges);
        pend_side = p;
        pend_aim  = aim;
        pend_row  = row;
        pend_kind = PEND_SERVE;
        drive_pad(p, make_pad(1'b1, aim, row));
        repeat (edges) @(posedge clk);
        #5;
        pend_kind   = PEND_NONE;
        model.pos.x = home_of(p);
        model.pos.y = row;
        model.aim   = aim;
        model.goal  = goal_of(p);
        check_puck(home_of(p), row);
        #5;
        drive_pad(p, make_pad(1'b0, aim, row));
    endtask

    task automatic wait_arrival(coord_t col);
        while (puck.x != col) begin
            paddle_a = random_pad();        // presses in travel are ignored
            paddle_b = random_pad();
            @(posedge clk);
            #10;
        end
        paddle_a = make_pad(1'b0, AIM_STRAIGHT, 3'd0);
        paddle_b = make_pad(1'b0, AIM_STRAIGHT, 3'd0);
    endtask

    task automatic return_puck(player_t p, aim_t aim);
        coord_t      row;
        puck_state_t after;
        row       = puck.y;
        after     = model;
        after.aim = aim;
        after.goal = goal_of(p);
        after     = ref_step(after);
        pend_side = p;
        pend_aim  = aim;
        pend_kind = PEND_RETURN;
        drive_pad(p, make_pad(1'b1, aim, row));
        @(posedge clk);
        #5;
        pend_kind = PEND_NONE;
        check_puck(after.pos.x, after.pos.y);
        #5;
        drive_pad(p, make_pad(1'b0, aim, row));
    endtask

    // defender swings at the wrong row until the window closes
    task automatic miss_puck(player_t defender);
        coord_t wrong;
        wrong = (puck.y == GRID_MAX) ? 3'd0 : puck.y + 3'd1;
        if (defender == PLAYER_A) exp_score_b = exp_score_b + 2'd1;
        else exp_score_a = exp_score_a + 2'd1;
        drive_pad(defender, make_pad(1'b1, AIM_STRAIGHT, wrong));
        @(score_a or score_b);
        #10;
        drive_pad(defender, make_pad(1'b0, AIM_STRAIGHT, wrong));
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : compare_puck
        puck_state_t expected;
        forever begin
            @(puck);
            #1;
            if (!rst) begin
                if (pend_kind == PEND_SERVE) begin
                    expected.pos.x = home_of(pend_side);
                    expected.pos.y = pend_row;
                    expected.aim   = pend_aim;
                    expected.goal  = goal_of(pend_side);
                end else if (pend_kind == PEND_RETURN) begin
                    expected      = model;
                    expected.aim  = pend_aim;
                    expected.goal = goal_of(pend_side);
                    expected      = ref_step(expected);
                end else begin
                    expected = ref_step(model);
                end
                check_value("puck x", 32'(puck.x), 32'(expected.pos.x));
                check_value("puck y", 32'(puck.y), 32'(expected.pos.y));
                model = expected;
            end
        end
    end

    initial begin : compare_score
        forever begin
            @(score_a or score_b);
            #1;
            if (!rst) begin
                check_value("score a", 32'(score_a), 32'(exp_score_a));
                check_value("score b", 32'(score_b), 32'(exp_score_b));
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: the game did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed        = 32'hfd9e_545e;
        pend_kind   = PEND_NONE;
        model       = '0;
        model.goal  = COL_B;
        exp_score_a = '0;
        exp_score_b = '0;
        paddle_a    = '0;
        paddle_b    = '0;
        rst         = 1'b1;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        check_puck(3'd0, 3'd0);
        check_value("game_over", 32'(game_over), 32'd0);

        // both or neither must not start a game
        paddle_a = make_pad(1'b1, AIM_STRAIGHT, 3'd2);
        paddle_b = make_pad(1'b1, AIM_STRAIGHT, 3'd2);
        repeat (2 * TICKS) @(posedge clk);
        #10;
        paddle_a = '0;
        paddle_b = '0;
        repeat (2 * TICKS) @(posedge clk);
        #10;
        check_puck(3'd0, 3'd0);
        check_value("score a", 32'(score_a), 32'd0);
        check_value("score b", 32'(score_b), 32'd0);
        check_value("game_over", 32'(game_over), 32'd0);

        serve_puck(PLAYER_A, 3'd2, AIM_STRAIGHT, TICKS + 2);   // start press is the serve
        wait_arrival(COL_B);
        check_puck(3'd4, 3'd2);
        return_puck(PLAYER_B, AIM_UP);
        wait_arrival(COL_A);
        check_puck(3'd0, 3'd2);
        miss_puck(PLAYER_A);

        serve_puck(PLAYER_A, 3'd3, AIM_UP, TICKS + 1);
        wait_arrival(COL_B);
        check_puck(3'd4, 3'd1);
        miss_puck(PLAYER_B);

        serve_puck(PLAYER_B, 3'd0, AIM_STRAIGHT, TICKS + 1);
        wait_arrival(COL_A);
        check_puck(3'd0, 3'd0);
        return_puck(PLAYER_A, AIM_DOWN);
        wait_arrival(COL_B);
        check_puck(3'd4, 3'd4);
        return_puck(PLAYER_B, AIM_UP);                         // return off the top wall
        wait_arrival(COL_A);
        check_puck(3'd0, 3'd0);
        miss_puck(PLAYER_A);

        serve_puck(PLAYER_A, 3'd1, AIM_DOWN, TICKS + 1);
        wait_arrival(COL_B);
        check_puck(3'd4, 3'd3);
        return_puck(PLAYER_B, aim_t'(2'b11));                  // unused code flies straight
        wait_arrival(COL_A);
        check_puck(3'd0, 3'd3);
        miss_puck(PLAYER_A);

        while (!game_over) begin
            @(posedge clk);
            #10;
        end
        check_value("winner", 32'(winner), 32'(PLAYER_B));
        held_puck = puck;
        repeat (3 * TICKS) begin
            paddle_a = random_pad();
            paddle_b = random_pad();
            @(posedge clk);
            #10;
        end
        check_puck(held_puck.x, held_puck.y);
        check_value("score a", 32'(score_a), 32'd1);
        check_value("score b", 32'(score_b), 32'd3);
        check_value("game_over", 32'(game_over), 32'd1);
        check_value("winner", 32'(winner), 32'(PLAYER_B));

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- project.f
logic/hockey_pkg.sv
logic/pace_timer.sv
logic/puck_mover.sv
logic/rink_ctrl.sv
logic/hockey_top.sv
test/hockey_sva.sv
test/hockey_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the hockey testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module hockey_tb -o hockey_sim

./obj_dir/hockey_sim | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
